/* logic/sdlc_pkg.sv */
`default_nettype none

package sdlc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] crc_t;
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [2:0]  run_cnt_t;

    // HDLC opening and closing flag.
    localparam byte_t SDLC_FLAG = 8'h7E;

    // CRC-16/X.25, reflected form.
    localparam crc_t CRC_POLY = 16'h8408;
    localparam crc_t CRC_INIT = 16'hFFFF;

    // A zero follows this many ones in data and check bits.
    localparam run_cnt_t MAX_ONES = 3'd5;

    // Register map.
    localparam apb_addr_t REG_DATA   = 4'h0;
    localparam apb_addr_t REG_CTRL   = 4'h4;
    localparam apb_addr_t REG_STATUS = 4'h8;

    typedef enum logic [2:0] {
        IDLE,
        OPEN_FLAG,
        DATA,
        CHECK,
        CLOSE_FLAG
    } tx_state_e;

endpackage

`default_nettype wire

/* logic/tx_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_apb_regs
    import sdlc_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                          clk,
    input  wire logic                          tx_crc_rst,
    input  wire logic                          psel,
    input  wire logic                          penable,
    input  wire logic                          pwrite,
    input  wire apb_addr_t                     paddr,
    input  wire apb_data_t                     pwdata,
    input  wire logic                          full,
    input  wire logic                          empty,
    input  wire logic [$clog2(FIFO_DEPTH):0]   level,
    input  wire logic                          tx_active,
    output apb_data_t                          prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               push,
    output byte_t                              push_data,
    output logic                               tx_en
);

    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    logic      access;
    logic      wr_access;
    logic      rd_access;
    logic      data_wr;
    apb_data_t status;

    // Access phase of a transfer.
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;
    assign data_wr   = wr_access && (paddr == REG_DATA);

    // No wait states.
    assign pready = 1'b1;

    // A byte written into a full FIFO is lost and flagged.
    assign pslverr   = data_wr && full;
    assign push      = data_wr && !full;
    assign push_data = pwdata[7:0];

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            tx_en <= 1'b0;
        end else if (wr_access && (paddr == REG_CTRL)) begin
            tx_en <= pwdata[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read back.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        status         = '0;
        status[0]      = tx_active;
        status[1]      = full;
        status[2]      = empty;
        status[8 +: LW] = level;
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                REG_CTRL:   prdata[0] = tx_en;
                REG_STATUS: prdata    = status;
                default:    prdata    = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/tx_byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_byte_fifo
    import sdlc_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                         clk,
    input  wire logic                         tx_crc_rst,
    input  wire logic                         push,
    input  wire byte_t                        push_data,
    input  wire logic                         pop,
    output byte_t                             rd_data,
    output logic                              empty,
    output logic                              full,
    output logic [$clog2(FIFO_DEPTH):0]       level
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int LW = AW + 1;

    byte_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [LW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Storage.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap since the depth is a power of two.
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word falls through.
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == LW'(FIFO_DEPTH));
    assign level   = count;

endmodule

`default_nettype wire

/* logic/tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_framer
    import sdlc_pkg::*;
#(
    parameter int BIT_DIV = 8
) (
    input  wire logic  clk,
    input  wire logic  tx_crc_rst,
    input  wire logic  tx_en,
    input  wire byte_t rd_data,
    input  wire logic  empty,
    input  wire logic  bit_taken,
    input  wire logic  crc_bit,
    output logic       pop,
    output logic       bit_tick,
    output logic       line_bit,
    output logic       stuff_en,
    output logic       crc_init,
    output logic       crc_shift,
    output logic       crc_out,
    output logic       data_bit,
    output logic       tx_clk,
    output logic       tx_active
);

    localparam int DW = $clog2(BIT_DIV);

    logic [DW-1:0] div_cnt;
    tx_state_e     state;
    logic [3:0]    bit_cnt;
    byte_t         shift_q;
    logic          adv;
    logic          start;
    logic          byte_end;
    logic          load_byte;

    ////////////////////////////////////////////////////////////////////////////
    // Bit-rate generator.
    ////////////////////////////////////////////////////////////////////////////

    assign bit_tick = (div_cnt == DW'(BIT_DIV - 1));

    // Transmit clock rises mid-bit.
    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            div_cnt <= '0;
            tx_clk  <= 1'b0;
        end else begin
            div_cnt <= bit_tick ? '0 : div_cnt + 1'b1;
            if (div_cnt == DW'(BIT_DIV / 2 - 1)) begin
                tx_clk <= 1'b1;
            end else if (bit_tick) begin
                tx_clk <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencing.
    ////////////////////////////////////////////////////////////////////////////

    // Current bit leaves on this tick unless a stuffed zero goes first.
    assign adv       = bit_tick && bit_taken;
    assign start     = bit_tick && (state == IDLE) && tx_en && !empty;
    assign byte_end  = (bit_cnt[2:0] == 3'd7);
    assign load_byte = adv && byte_end && !empty &&
                       ((state == OPEN_FLAG) || (state == DATA));

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            tx_active <= 1'b0;
        end else begin
            if (bit_tick) begin
                tx_active <= (state != IDLE) || start;
            end
            if (start) begin
                state   <= OPEN_FLAG;
                bit_cnt <= '0;
            end else if (adv) begin
                bit_cnt <= bit_cnt + 1'b1;
                case (state)
                    OPEN_FLAG, DATA: begin
                        // Empty FIFO at a byte boundary ends the data.
                        if (byte_end) begin
                            bit_cnt <= '0;
                            state   <= empty ? CHECK : DATA;
                        end
                    end
                    CHECK: begin
                        if (bit_cnt == 4'd15) begin
                            bit_cnt <= '0;
                            state   <= CLOSE_FLAG;
                        end
                    end
                    CLOSE_FLAG: begin
                        if (byte_end) begin
                            bit_cnt <= '0;
                            state   <= IDLE;
                        end
                    end
                    default: bit_cnt <= '0;
                endcase
            end
        end
    end

    // Byte serializer, LSB first.
    always_ff @(posedge clk) begin
        if (load_byte) begin
            shift_q <= rd_data;
        end else if (adv && (state == DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign pop = load_byte;

    always_comb begin
        case (state)
            OPEN_FLAG, CLOSE_FLAG: line_bit = SDLC_FLAG[bit_cnt[2:0]];
            DATA:                  line_bit = shift_q[0];
            CHECK:                 line_bit = crc_bit;
            default:               line_bit = 1'b1;
        endcase
    end

    // Flags are sent without stuffing.
    assign stuff_en  = (state == DATA) || (state == CHECK);

    assign crc_init  = start;
    assign crc_shift = adv && stuff_en;
    assign crc_out   = (state == CHECK);
    assign data_bit  = shift_q[0];

endmodule

`default_nettype wire

/* logic/tx_crc16.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_crc16
    import sdlc_pkg::*;
(
    input  wire logic clk,
    input  wire logic tx_crc_rst,
    input  wire logic crc_init,
    input  wire logic crc_shift,
    input  wire logic crc_out,
    input  wire logic data_bit,
    output logic      crc_bit
);

    crc_t crc_q;
    logic fb;

    // Reflected form, so the feedback taps bit 0.
    assign fb = crc_q[0] ^ data_bit;

    always_ff @(posedge clk) begin
        if (tx_crc_rst || crc_init) begin
            crc_q <= CRC_INIT;
        end else if (crc_shift) begin
            if (crc_out) begin
                // Check sequence goes out LSB first.
                crc_q <= {1'b0, crc_q[15:1]};
            end else begin
                crc_q <= {1'b0, crc_q[15:1]} ^ (fb ? CRC_POLY : crc_t'(0));
            end
        end
    end

    // Register is sent complemented.
    assign crc_bit = ~crc_q[0];

endmodule

`default_nettype wire

/* logic/tx_zero_inserter.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_zero_inserter
    import sdlc_pkg::*;
(
    input  wire logic clk,
    input  wire logic tx_crc_rst,
    input  wire logic bit_tick,
    input  wire logic line_bit,
    input  wire logic stuff_en,
    output logic      tx_data,
    output logic      bit_taken
);

    run_cnt_t ones_cnt;
    logic     stuff_slot;

    // A full run is stuffed even if stuffing just ended,
    // as after a final check bit of one.
    assign stuff_slot = (ones_cnt == MAX_ONES);
    assign bit_taken  = !stuff_slot;

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            tx_data  <= 1'b1;
            ones_cnt <= '0;
        end else if (bit_tick) begin
            if (stuff_slot) begin
                // Inserted zero.
                tx_data  <= 1'b0;
                ones_cnt <= '0;
            end else begin
                tx_data <= line_bit;
                if (stuff_en && line_bit) begin
                    ones_cnt <= ones_cnt + 1'b1;
                end else begin
                    ones_cnt <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sdlc_tx_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module sdlc_tx_apb
    import sdlc_pkg::*;
#(
    parameter int BIT_DIV    = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic      clk,
    input  wire logic      tx_crc_rst,
    // APB slave.
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    // Line side.
    output logic           tx_data,
    output logic           tx_clk,
    output logic           tx_active
);

    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    logic          push;
    byte_t         push_data;
    logic          pop;
    byte_t         rd_data;
    logic          empty;
    logic          full;
    logic [LW-1:0] level;
    logic          tx_en;

    logic bit_tick;
    logic line_bit;
    logic stuff_en;
    logic bit_taken;
    logic crc_init;
    logic crc_shift;
    logic crc_out;
    logic data_bit;
    logic crc_bit;

    tx_apb_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) tx_apb_regs_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .full       (full),
        .empty      (empty),
        .level      (level),
        .tx_active  (tx_active),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .push       (push),
        .push_data  (push_data),
        .tx_en      (tx_en)
    );

    tx_byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) tx_byte_fifo_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .rd_data    (rd_data),
        .empty      (empty),
        .full       (full),
        .level      (level)
    );

    tx_framer #(
        .BIT_DIV(BIT_DIV)
    ) tx_framer_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .tx_en      (tx_en),
        .rd_data    (rd_data),
        .empty      (empty),
        .bit_taken  (bit_taken),
        .crc_bit    (crc_bit),
        .pop        (pop),
        .bit_tick   (bit_tick),
        .line_bit   (line_bit),
        .stuff_en   (stuff_en),
        .crc_init   (crc_init),
        .crc_shift  (crc_shift),
        .crc_out    (crc_out),
        .data_bit   (data_bit),
        .tx_clk     (tx_clk),
        .tx_active  (tx_active)
    );

    tx_crc16 tx_crc16_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .crc_init   (crc_init),
        .crc_shift  (crc_shift),
        .crc_out    (crc_out),
        .data_bit   (data_bit),
        .crc_bit    (crc_bit)
    );

    tx_zero_inserter tx_zero_inserter_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .bit_tick   (bit_tick),
        .line_bit   (line_bit),
        .stuff_en   (stuff_en),
        .tx_data    (tx_data),
        .bit_taken  (bit_taken)
    );

endmodule

`default_nettype wire

/* test/sdlc_tx_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sdlc_tx_assert
    import sdlc_pkg::*;
(
    input wire logic clk,
    input wire logic tx_crc_rst,
    input wire logic bit_tick,
    input wire logic stuff_en,
    input wire logic tx_data,
    input wire logic bit_taken
);

    run_cnt_t line_ones;
    logic     tick_q;
    logic     stuffing_q;

    // Ones run as seen on the line, counted one clock after each bit boundary.
    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            line_ones  <= '0;
            tick_q     <= 1'b0;
            stuffing_q <= 1'b0;
        end else begin
            tick_q <= bit_tick;
            if (bit_tick) begin
                stuffing_q <= stuff_en;
            end
            if (tick_q) begin
                line_ones <= (tx_data && stuffing_q) ? line_ones + 1'b1 : '0;
            end
        end
    end

    // Run of ones on the line stays bounded while stuffing.
    run_bound: assert property (@(posedge clk) disable iff (tx_crc_rst)
        stuff_en |-> (line_ones <= MAX_ONES))
        else $error("line carried %0d ones in a row", line_ones);

    // Line moves only on the bit boundary.
    line_timing: assert property (@(posedge clk) disable iff (tx_crc_rst)
        (tx_data != $past(tx_data)) |-> $past(bit_tick))
        else $error("tx_data changed away from a bit boundary");

    // A held bit follows five ones on the line.
    stuff_hold: assert property (@(posedge clk) disable iff (tx_crc_rst)
        (bit_tick && !bit_taken) |-> (line_ones == MAX_ONES))
        else $error("bit held without a full run of ones");

    stuff_zero: assert property (@(posedge clk) disable iff (tx_crc_rst)
        (bit_tick && !bit_taken) |=> !tx_data)
        else $error("stuffed slot did not send a zero");

endmodule

`default_nettype wire

/* test/tb_sdlc_tx_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdlc_tx_apb
    import sdlc_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int BIT_DIV    = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int N_RAND     = 6;
    localparam int N_STUFF    = 5;
    localparam int N_A        = 5;
    localparam int N_B        = 7;

    logic      clk;
    logic      tx_crc_rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      tx_data;
    logic      tx_clk;
    logic      tx_active;

    int          errors         = 0;
    int          tests_run      = 0;
    int          tests_failed   = 0;
    int          frames_queued  = 0;
    int          frames_decoded = 0;
    int          frames_checked = 0;
    logic [31:0] lfsr           = 32'h6fb87b42;
    byte_t       pending   [$];
    byte_t       exp_bytes [$];
    byte_t       got_bytes [$];
    int          exp_len   [$];
    int          exp_stuff [$];
    int          got_len   [$];
    int          got_stuff [$];

    sdlc_tx_apb #(
        .BIT_DIV    (BIT_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdlc_tx_apb_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tx_data    (tx_data),
        .tx_clk     (tx_clk),
        .tx_active  (tx_active)
    );

    bind tx_zero_inserter sdlc_tx_assert sdlc_tx_assert_i (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .bit_tick   (bit_tick),
        .stuff_en   (stuff_en),
        .tx_data    (tx_data),
        .bit_taken  (bit_taken)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic byte_t random_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    // CRC-16/X.25 over whole bytes, LSB first, complemented.
    function automatic crc_t ref_crc(input byte_t data[$]);
        crc_t c;
        c = CRC_INIT;
        foreach (data[i]) begin
            c = c ^ crc_t'(data[i]);
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // Zeros the line must carry after each run of five ones.
    function automatic int ref_stuffed(input byte_t data[$]);
        int ones;
        int n;
        ones = 0;
        n    = 0;
        foreach (data[i]) begin
            for (int k = 0; k < 8; k++) begin
                if (data[i][k]) begin
                    ones++;
                    if (ones == 5) begin
                        n++;
                        ones = 0;
                    end
                end else begin
                    ones = 0;
                end
            end
        end
        return n;
    endfunction

    // Flags, data, check sequence, worst-case stuffing, start and idle bits.
    function automatic int frame_bits(input int n);
        return 8 + 8 * n + 16 + 8 + (8 * n + 16) / 5 + 2;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB and test helpers.
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #(CLK_PERIOD / 2);
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            $display("Mismatch at %0t: pready %b in access phase, expected 1",
                     $time, pready);
            errors++;
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic push_byte(input byte_t b, input logic expect_err);
        apb_data_t rd;
        logic      err;
        apb_access(1'b1, REG_DATA, apb_data_t'(b), rd, err);
        if (err !== expect_err) begin
            $display("Mismatch at %0t: pslverr %b on data write, expected %b",
                     $time, err, expect_err);
            errors++;
        end
        if (!expect_err) pending.push_back(b);
    endtask

    task automatic set_enable(input logic en);
        apb_data_t rd;
        logic      err;
        apb_access(1'b1, REG_CTRL, apb_data_t'(en), rd, err);
    endtask

    task automatic check_status(input logic busy, input logic full_exp,
                                input logic empty_exp, input int lvl);
        apb_data_t s;
        apb_data_t e;
        logic      err;
        apb_access(1'b0, REG_STATUS, '0, s, err);
        e       = '0;
        e[0]    = busy;
        e[1]    = full_exp;
        e[2]    = empty_exp;
        e[12:8] = lvl[4:0];
        if (s !== e) begin
            $display("Mismatch at %0t: status %08h, expected %08h", $time, s, e);
            errors++;
        end
    endtask

    // Pending bytes plus their check sequence become the next expected frame.
    task automatic queue_expected();
        crc_t fcs;
        fcs = ref_crc(pending);
        pending.push_back(fcs[7:0]);
        pending.push_back(fcs[15:8]);
        foreach (pending[i]) exp_bytes.push_back(pending[i]);
        exp_len.push_back(pending.size());
        exp_stuff.push_back(ref_stuffed(pending));
        pending.delete();
        frames_queued++;
    endtask

    task automatic send_frames();
        set_enable(1'b1);
        wait (frames_checked == frames_queued);
        set_enable(1'b0);
        wait (!tx_active);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Line decoder, sampling mid-bit.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    ones;
        int    stuffed;
        logic  in_frame;
        logic  bits [$];
        byte_t v;
        ones     = 7;
        stuffed  = 0;
        in_frame = 1'b0;
        forever begin
            @(posedge tx_clk);
            if (tx_data) begin
                if (ones < 7) ones++;
                // Seven ones is idle line, not a frame.
                if (ones == 7) begin
                    in_frame = 1'b0;
                    bits.delete();
                end else begin
                    bits.push_back(1'b1);
                end
            end else begin
                if (ones == 5) begin
                    stuffed++;
                end else if (ones == 6) begin
                    // Drop the flag's own leading zero and six ones.
                    repeat (7) begin
                        if (bits.size() > 0) void'(bits.pop_back());
                    end
                    if (in_frame && bits.size() >= 8) begin
                        if (bits.size() % 8 != 0) begin
                            $display("Error at %0t: frame of %0d bits is not whole bytes",
                                     $time, bits.size());
                            errors++;
                        end
                        for (int i = 0; i < bits.size() / 8; i++) begin
                            for (int k = 0; k < 8; k++) begin
                                v[k] = bits[8 * i + k];
                            end
                            got_bytes.push_back(v);
                        end
                        got_len.push_back(bits.size() / 8);
                        got_stuff.push_back(stuffed);
                        frames_decoded++;
                    end
                    in_frame = 1'b1;
                    bits.delete();
                    stuffed = 0;
                end else begin
                    bits.push_back(1'b0);
                end
                ones = 0;
            end
        end
    end

    // Compare each decoded frame with the next expected one.
    initial begin
        int    got_n;
        int    got_s;
        int    exp_n;
        int    exp_s;
        byte_t e;
        byte_t g;
        forever begin
            wait (frames_decoded > frames_checked);
            got_n = got_len.pop_front();
            got_s = got_stuff.pop_front();
            if (exp_len.size() == 0) begin
                $display("Error at %0t: a frame was decoded that no test sent", $time);
                errors++;
                exp_n = 0;
            end else begin
                exp_n = exp_len.pop_front();
                exp_s = exp_stuff.pop_front();
                if (got_n != exp_n) begin
                    $display("Mismatch at %0t: frame %0d has %0d bytes, expected %0d",
                             $time, frames_checked, got_n, exp_n);
                    errors++;
                end
                if (got_s != exp_s) begin
                    $display("Mismatch at %0t: frame %0d removed %0d zeros, expected %0d",
                             $time, frames_checked, got_s, exp_s);
                    errors++;
                end
            end
            for (int i = 0; i < exp_n; i++) begin
                e = exp_bytes.pop_front();
                if (i < got_n) begin
                    g = got_bytes.pop_front();
                    if (g !== e) begin
                        $display("Mismatch at %0t: frame %0d byte %0d is %02h, expected %02h",
                                 $time, frames_checked, i, g, e);
                        errors++;
                    end
                end
            end
            for (int i = exp_n; i < got_n; i++) begin
                void'(got_bytes.pop_front());
            end
            frames_checked++;
        end
    end

    initial begin
        int limit;
        limit = frame_bits(N_RAND) + frame_bits(N_STUFF) + frame_bits(FIFO_DEPTH) +
                frame_bits(N_A) + frame_bits(N_B) + 64;
        limit = limit * BIT_DIV * 2;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clocks", limit);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    e0;
        byte_t stuff_bytes [N_STUFF];
        stuff_bytes = '{8'hFF, 8'h7E, 8'h3F, 8'hFF, 8'hFF};
        tx_crc_rst  = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (16) @(posedge clk);
        #2;
        tx_crc_rst = 1'b0;

        e0 = errors;
        @(posedge clk);
        #2;
        if (tx_data !== 1'b1 || tx_active !== 1'b0) begin
            $display("Mismatch at %0t: tx_data %b tx_active %b after reset, expected 1 0",
                     $time, tx_data, tx_active);
            errors++;
        end
        check_status(1'b0, 1'b0, 1'b1, 0);
        finish_test("reset state", e0);

        e0 = errors;
        repeat (N_RAND) push_byte(random_byte(), 1'b0);
        queue_expected();
        send_frames();
        check_status(1'b0, 1'b0, 1'b1, 0);
        finish_test("random frame", e0);

        e0 = errors;
        foreach (stuff_bytes[i]) push_byte(stuff_bytes[i], 1'b0);
        queue_expected();
        send_frames();
        finish_test("zero insertion", e0);

        e0 = errors;
        repeat (FIFO_DEPTH) push_byte(random_byte(), 1'b0);
        check_status(1'b0, 1'b1, 1'b0, FIFO_DEPTH);
        push_byte(8'hA5, 1'b1);
        queue_expected();
        send_frames();
        check_status(1'b0, 1'b0, 1'b1, 0);
        finish_test("full FIFO", e0);

        // Two frames with the transmitter left enabled.
        e0 = errors;
        set_enable(1'b1);
        repeat (N_A) push_byte(random_byte(), 1'b0);
        queue_expected();
        wait (frames_checked == frames_queued);
        repeat (N_B) push_byte(random_byte(), 1'b0);
        queue_expected();
        wait (frames_checked == frames_queued);
        wait (!tx_active);
        check_status(1'b0, 1'b0, 1'b1, 0);
        set_enable(1'b0);
        finish_test("two frames", e0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sdlc_tx_apb.f */
logic/sdlc_pkg.sv
logic/tx_apb_regs.sv
logic/tx_byte_fifo.sv
logic/tx_framer.sv
logic/tx_crc16.sv
logic/tx_zero_inserter.sv
logic/sdlc_tx_apb.sv
test/sdlc_tx_assert.sv
test/tb_sdlc_tx_apb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdlc_tx_apb \
    -f sdlc_tx_apb.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
